/* Makefile */
# Verilator build and run of the LDPC encoder testbench

VERILATOR ?= verilator
TOP       ?= ldpc_enc_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
# keep running past assertion errors so the testbench prints its summary
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Test failed

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/ldpc_enc_ctrl.sv */
// one block at a time; no stall once started, read data must return exactly cRDAT_DELAY later
module ldpc_enc_ctrl (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               ifull,
  input  logic               iwbuf_empty,
  input  logic               iblock_done,
  output ldpc_enc_pkg::col_t oraddr,
  output logic               orempty,
  output logic               obusy,
  ldpc_enc_cycle_if.src      rd
);
  import ldpc_enc_pkg::*;

  // everything that travels with one read
  typedef struct packed {
    cyc_op_t op;
    col_t    col;
    shift_t  shift;
    row_t    row;
    logic    last_in_row;
    logic    last_rd;
  } issue_t;

  ctrl_state_t            state;
  logic [cHS_IDX_W-1:0]   idx;

  hs_entry_t              hs_cur;
  hs_entry_t              hs_nxt;

  logic                   iss_val;
  issue_t                 iss;

  logic [cRDAT_DELAY-1:0] dly_val;
  issue_t                 dly [cRDAT_DELAY];

  //--------------------------------------------------------------------------
  // block state machine
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= st_idle;
      idx   <= '0;
    end else begin
      case (state)
        st_idle: begin
          idx <= '0;
          // input full and output drained
          if (ifull && iwbuf_empty) begin
            state <= st_data;
          end
        end
        st_data: begin
          if (idx == cHS_IDX_W'(cDATA_COLS - 1)) begin
            idx   <= '0;
            state <= st_parity;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        st_parity: begin
          if (idx == cHS_IDX_W'(cHS_ENTRIES - 1)) begin
            state <= st_drain;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        st_drain: begin
          // pipeline still flushing, wait for the output side
          if (iblock_done) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // read issue
  //--------------------------------------------------------------------------

  always_comb begin
    hs_cur = cHS_TABLE[idx];
    // no entry past the end, so reuse the current one
    hs_nxt = (idx == cHS_IDX_W'(cHS_ENTRIES - 1)) ? hs_cur : cHS_TABLE[idx + 1'b1];
    iss     = '0;
    iss_val = 1'b0;
    case (state)
      st_data: begin
        // systematic words in column order, no rotation
        iss_val = 1'b1;
        iss.op  = op_data;
        iss.col = idx[1:0];
      end
      st_parity: begin
        iss_val         = 1'b1;
        iss.op          = op_parity;
        iss.col         = hs_cur.col;
        iss.shift       = hs_cur.shift;
        iss.row         = hs_cur.row;
        // row closes where the next entry moves on or the table ends
        iss.last_rd     = (idx == cHS_IDX_W'(cHS_ENTRIES - 1));
        iss.last_in_row = iss.last_rd || (hs_nxt.row != hs_cur.row);
      end
      default: begin
        iss_val = 1'b0;
      end
    endcase
  end

  // stays at column 0 while idle
  assign oraddr = iss.col;

  //--------------------------------------------------------------------------
  // align control with read data
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      dly_val <= '0;
    end else begin
      dly_val <= {dly_val[cRDAT_DELAY-2:0], iss_val};
    end
  end

  always_ff @(posedge iclk) begin
    dly[0] <= iss;
    for (int i = 1; i < cRDAT_DELAY; i++) begin
      dly[i] <= dly[i-1];
    end
  end

  assign rd.val         = dly_val[cRDAT_DELAY-1];
  assign rd.op          = dly[cRDAT_DELAY-1].op;
  assign rd.col         = dly[cRDAT_DELAY-1].col;
  assign rd.shift       = dly[cRDAT_DELAY-1].shift;
  assign rd.row         = dly[cRDAT_DELAY-1].row;
  assign rd.last_in_row = dly[cRDAT_DELAY-1].last_in_row;
  // word is on irdat, not in the cycle record
  assign rd.dat         = '0;

  // input buffer free once the final read word is taken
  assign orempty = rd.val && dly[cRDAT_DELAY-1].last_rd;

  assign obusy = (state != st_idle);

endmodule

/* design/ldpc_enc_cycle_if.sv */
// dat is only meaningful on the rotator output; the read word itself comes on irdat
interface ldpc_enc_cycle_if;
  import ldpc_enc_pkg::*;

  // cycle valid
  logic    val;
  // data or schedule read
  cyc_op_t op;
  // source column and rotation
  col_t    col;
  shift_t  shift;
  // parity row and its closing flag
  row_t    row;
  logic    last_in_row;
  // rotated word, shift already applied
  zdat_t   dat;

  // producer side
  modport src (output val, op, col, shift, row, last_in_row, dat);

  // consumer side
  modport dst (input val, op, col, shift, row, last_in_row, dat);

endinterface

/* design/ldpc_enc_out_mux.sv */
// data and parity writes must not coincide; the schedule keeps them apart
module ldpc_enc_out_mux (
  input  logic                  iclk,
  input  logic                  ireset,
  ldpc_enc_cycle_if.dst         rd,
  input  ldpc_enc_pkg::zdat_t   irdat,
  input  logic                  pval,
  input  ldpc_enc_pkg::row_t    prow,
  input  ldpc_enc_pkg::zdat_t   pword,
  output logic                  owrite,
  output ldpc_enc_pkg::waddr_t  owaddr,
  output ldpc_enc_pkg::zdat_t   owdat,
  output logic                  owfull
);
  import ldpc_enc_pkg::*;

  logic   take_dat;
  waddr_t last_waddr;

  // systematic word straight from the input buffer
  assign take_dat = rd.val && (rd.op == op_data);

  // final parity slot of the block
  assign last_waddr = waddr_t'(cDATA_COLS + cPAR_ROWS - 1);

  //--------------------------------------------------------------------------
  // write strobes
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      owrite <= 1'b0;
      owfull <= 1'b0;
    end else begin
      owrite <= take_dat || pval;
      // block end, the cycle after the last parity write
      owfull <= owrite && (owaddr == last_waddr);
    end
  end

  //--------------------------------------------------------------------------
  // address and data
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (take_dat) begin
      // data at 0..3
      owaddr <= waddr_t'(rd.col);
      owdat  <= irdat;
    end else if (pval) begin
      // parity placed after the data words
      owaddr <= waddr_t'(cDATA_COLS) + waddr_t'(prow);
      owdat  <= pword;
    end
  end

endmodule

/* design/ldpc_enc_pacc.sv */
// rows must arrive in order and contiguous, row 0 first in every block
module ldpc_enc_pacc (
  input  logic                 iclk,
  input  logic                 ireset,
  ldpc_enc_cycle_if.dst        rot,
  output logic                 pval,
  output ldpc_enc_pkg::row_t   prow,
  output ldpc_enc_pkg::zdat_t  pword
);
  import ldpc_enc_pkg::*;

  logic  take;
  logic  row_end;
  zdat_t acc;
  zdat_t acc_sum;
  zdat_t chain;
  zdat_t chain_prev;

  //--------------------------------------------------------------------------
  // row accumulator
  //--------------------------------------------------------------------------

  // data cycles pass through the rotator too, skip them
  assign take    = rot.val && (rot.op == op_parity);
  assign row_end = take && rot.last_in_row;

  // includes the word arriving now
  assign acc_sum = acc ^ rot.dat;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      acc  <= '0;
      pval <= 1'b0;
    end else begin
      pval <= row_end;
      if (take) begin
        // restart at each row boundary
        acc <= rot.last_in_row ? '0 : acc_sum;
      end
    end
  end

  //--------------------------------------------------------------------------
  // dual-diagonal chain
  //--------------------------------------------------------------------------

  // first row has no upper neighbour
  assign chain_prev = (rot.row == '0) ? '0 : chain;

  // p(r) = p(r-1) ^ acc(r), held until the next row closes
  always_ff @(posedge iclk) begin
    if (row_end) begin
      chain <= chain_prev ^ acc_sum;
      prow  <= rot.row;
    end
  end

  // chain register doubles as the output word
  assign pword = chain;

endmodule

/* design/ldpc_enc_pkg.sv */
// one fixed code only: 4 data words of 8 bits, 3 parity rows; schedule rows must never decrease
package ldpc_enc_pkg;

  //--------------------------------------------------------------------------
  // code geometry
  //--------------------------------------------------------------------------

  // circulant size, equal to the word width
  localparam int cZC         = 8;
  localparam int cLOG2_ZC    = 3;
  // words per block
  localparam int cDATA_COLS  = 4;
  localparam int cPAR_ROWS   = 3;
  // schedule length and index width (also covers the data walk)
  localparam int cHS_ENTRIES = 8;
  localparam int cHS_IDX_W   = 3;
  // input buffer read latency in cycles
  localparam int cRDAT_DELAY = 2;

  //--------------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------------

  typedef logic [cZC-1:0]      zdat_t;
  typedef logic [1:0]          col_t;
  typedef logic [1:0]          row_t;
  typedef logic [cLOG2_ZC-1:0] shift_t;
  typedef logic [2:0]          waddr_t;

  // one check-matrix entry, 7 bits
  typedef struct packed {
    row_t   row;
    col_t   col;
    shift_t shift;
  } hs_entry_t;

  // cycle kind carried down the pipeline
  typedef enum logic {
    op_data,
    op_parity
  } cyc_op_t;

  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_parity,
    st_drain
  } ctrl_state_t;

  //--------------------------------------------------------------------------
  // schedule, walked in order; fields are row, col, shift
  //--------------------------------------------------------------------------

  localparam hs_entry_t cHS_TABLE [cHS_ENTRIES] = '{
    '{2'd0, 2'd0, 3'd1}, '{2'd0, 2'd2, 3'd5},
    '{2'd1, 2'd1, 3'd0}, '{2'd1, 2'd3, 3'd2}, '{2'd1, 2'd0, 3'd7},
    '{2'd2, 2'd2, 3'd3}, '{2'd2, 2'd3, 3'd6}, '{2'd2, 2'd1, 3'd4}
  };

endpackage

/* design/ldpc_enc_rotator.sv */
// left rotation only, shift below cZC; one cycle latency, no stall
module ldpc_enc_rotator (
  input  logic                iclk,
  input  logic                ireset,
  input  ldpc_enc_pkg::zdat_t irdat,
  ldpc_enc_cycle_if.dst       rd,
  ldpc_enc_cycle_if.src       rot
);
  import ldpc_enc_pkg::*;

  // cyclic left rotate through a doubled word
  function automatic zdat_t rotl(zdat_t x, shift_t s);
    logic [2*cZC-1:0] dbl;
    dbl = {x, x} << s;
    return dbl[2*cZC-1 -: cZC];
  endfunction

  zdat_t                 dat_coarse;
  zdat_t                 dat_q;
  logic [cLOG2_ZC-2:0]   shift_lo_q;
  logic                  val_q;
  cyc_op_t               op_q;
  row_t                  row_q;
  logic                  last_q;

  // coarse stage, top shift bit only
  assign dat_coarse = rotl(irdat, {rd.shift[cLOG2_ZC-1], {(cLOG2_ZC-1){1'b0}}});

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_q <= 1'b0;
    end else begin
      val_q <= rd.val;
    end
  end

  always_ff @(posedge iclk) begin
    dat_q      <= dat_coarse;
    shift_lo_q <= rd.shift[cLOG2_ZC-2:0];
    op_q       <= rd.op;
    row_q      <= rd.row;
    last_q     <= rd.last_in_row;
  end

  // fine stage after the register
  assign rot.dat         = rotl(dat_q, {1'b0, shift_lo_q});
  assign rot.val         = val_q;
  assign rot.op          = op_q;
  assign rot.row         = row_q;
  assign rot.last_in_row = last_q;
  // source column not needed past the rotator
  assign rot.col         = '0;
  // nothing left to rotate
  assign rot.shift       = '0;

endmodule

/* design/ldpc_enc_top.sv */
// fixed code encoder; input buffer read latency must be exactly cRDAT_DELAY cycles
module ldpc_enc_top (
  input  logic                  iclk,
  input  logic                  ireset,
  // input buffer side
  input  logic                  ifull,
  input  ldpc_enc_pkg::zdat_t   irdat,
  output ldpc_enc_pkg::col_t    oraddr,
  output logic                  orempty,
  // output buffer side
  input  logic                  iwbuf_empty,
  output logic                  owrite,
  output ldpc_enc_pkg::waddr_t  owaddr,
  output ldpc_enc_pkg::zdat_t   owdat,
  output logic                  owfull,
  output logic                  obusy
);
  import ldpc_enc_pkg::*;

  // aligned read cycle and rotated cycle
  ldpc_enc_cycle_if rd ();
  ldpc_enc_cycle_if rot ();

  // parity strobe into the mux
  logic  pval;
  row_t  prow;
  zdat_t pword;

  //--------------------------------------------------------------------------
  // engine
  //--------------------------------------------------------------------------

  ldpc_enc_ctrl u_ctrl (
    .iclk        (iclk),
    .ireset      (ireset),
    .ifull       (ifull),
    .iwbuf_empty (iwbuf_empty),
    // block done closes the busy window
    .iblock_done (owfull),
    .oraddr      (oraddr),
    .orempty     (orempty),
    .obusy       (obusy),
    .rd          (rd)
  );

  ldpc_enc_rotator u_rotator (
    .iclk   (iclk),
    .ireset (ireset),
    .irdat  (irdat),
    .rd     (rd),
    .rot    (rot)
  );

  ldpc_enc_pacc u_pacc (
    .iclk   (iclk),
    .ireset (ireset),
    .rot    (rot),
    .pval   (pval),
    .prow   (prow),
    .pword  (pword)
  );

  ldpc_enc_out_mux u_out_mux (
    .iclk   (iclk),
    .ireset (ireset),
    .rd     (rd),
    .irdat  (irdat),
    .pval   (pval),
    .prow   (prow),
    .pword  (pword),
    .owrite (owrite),
    .owaddr (owaddr),
    .owdat  (owdat),
    .owfull (owfull)
  );

endmodule

/* list.f */
design/ldpc_enc_pkg.sv
design/ldpc_enc_cycle_if.sv
design/ldpc_enc_ctrl.sv
design/ldpc_enc_rotator.sv
design/ldpc_enc_pacc.sv
design/ldpc_enc_out_mux.sv
design/ldpc_enc_top.sv
sim/ldpc_enc_assertions.sv
sim/ldpc_enc_tb.sv

/* sim/ldpc_enc_assertions.sv */
// top-level protocol only, sampled on the rising clock and idle while reset is high
module ldpc_enc_assertions (
  input logic                 iclk,
  input logic                 ireset,
  input logic                 orempty,
  input logic                 owrite,
  input ldpc_enc_pkg::waddr_t owaddr,
  input logic                 owfull,
  input logic                 obusy
);
  import ldpc_enc_pkg::*;

  localparam int cNUM_WORDS = cDATA_COLS + cPAR_ROWS;

  // one tally per property
  int fail_waddr   = 0;
  int fail_full    = 0;
  int fail_overlap = 0;
  int fail_rempty  = 0;
  int fail_count;

  assign fail_count = fail_waddr + fail_full + fail_overlap + fail_rempty;

  //--------------------------------------------------------------------------
  // properties
  //--------------------------------------------------------------------------

  // writes stay inside the seven-word block
  a_waddr_range: assert property (@(posedge iclk) disable iff (ireset)
    owrite |-> (32'(owaddr) < cNUM_WORDS))
    else begin fail_waddr++; $error("write address out of range"); end

  a_full_busy: assert property (@(posedge iclk) disable iff (ireset) owfull |-> obusy)
    else begin fail_full++; $error("block end outside busy window"); end

  // block end strobe comes after the last write
  a_full_write: assert property (@(posedge iclk) disable iff (ireset) !(owfull && owrite))
    else begin fail_overlap++; $error("block end together with a write"); end

  a_rempty_busy: assert property (@(posedge iclk) disable iff (ireset) orempty |-> obusy)
    else begin fail_rempty++; $error("input release outside busy window"); end

endmodule

bind ldpc_enc_top ldpc_enc_assertions u_assertions (
  .iclk    (iclk),
  .ireset  (ireset),
  .orempty (orempty),
  .owrite  (owrite),
  .owaddr  (owaddr),
  .owfull  (owfull),
  .obusy   (obusy)
);

/* sim/ldpc_enc_tb.sv */
// fixed code only; input buffer modelled with exactly cRDAT_DELAY cycles of read latency
module ldpc_enc_tb;
  import ldpc_enc_pkg::*;

  localparam int          cNUM_BLOCKS   = 6;
  localparam int          cRESET_CYCLES = 10;
  localparam int          cIDLE_CYCLES  = 8;
  localparam int          cBLOCK_CYCLES = 60;
  localparam int          cMAX_CYCLES   = cRESET_CYCLES + cIDLE_CYCLES
                                          + cNUM_BLOCKS * cBLOCK_CYCLES;
  localparam int          cNUM_WORDS    = cDATA_COLS + cPAR_ROWS;
  localparam logic [31:0] cLFSR_SEED    = 32'hf0a4_2800;
  // x^32 + x^22 + x^2 + x + 1, right shifting form
  localparam logic [31:0] cLFSR_TAPS    = 32'h8020_0003;

  logic   iclk = 1'b0;
  logic   ireset;
  logic   ifull;
  logic   iwbuf_empty;
  zdat_t  irdat;
  col_t   oraddr;
  logic   orempty;
  logic   owrite;
  waddr_t owaddr;
  zdat_t  owdat;
  logic   owfull;
  logic   obusy;

  // stimulus table, one row per block
  logic [cDATA_COLS*cZC-1:0] stim_words [cNUM_BLOCKS];
  int                        holdoff    [cNUM_BLOCKS];

  zdat_t       ibuf    [cDATA_COLS]  = '{default: '0};
  zdat_t       rd_pipe [cRDAT_DELAY] = '{default: '0};
  logic [31:0] lfsr;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          assert_fails;

  ldpc_enc_top DUT (
    .iclk        (iclk),
    .ireset      (ireset),
    .ifull       (ifull),
    .irdat       (irdat),
    .oraddr      (oraddr),
    .orempty     (orempty),
    .iwbuf_empty (iwbuf_empty),
    .owrite      (owrite),
    .owaddr      (owaddr),
    .owdat       (owdat),
    .owfull      (owfull),
    .obusy       (obusy)
  );

  always #20 iclk = ~iclk;

  //--------------------------------------------------------------------------
  // input buffer model and cycle limit
  //--------------------------------------------------------------------------

  // address taken at one edge, word on irdat two edges later
  always @(posedge iclk) begin
    rd_pipe[0] <= ibuf[oraddr];
    for (int i = 1; i < cRDAT_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign irdat = rd_pipe[cRDAT_DELAY-1];

  always @(posedge iclk) begin
    if (cycles < cMAX_CYCLES) begin
      cycles <= cycles + 1;
    end else begin
      $display("timeout: engine did not finish all blocks within %0d cycles", cMAX_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Test failed");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // helpers and reference model
  //--------------------------------------------------------------------------

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ cLFSR_TAPS) : (s >> 1);
  endfunction

  // bit i lands on bit i+s modulo the circulant size
  function automatic zdat_t rotate_left(zdat_t x, int s);
    zdat_t y;
    for (int i = 0; i < cZC; i++) begin
      y[(i + s) % cZC] = x[i];
    end
    return y;
  endfunction

  // row sums of rotated columns, then the dual-diagonal running XOR
  function automatic logic [cPAR_ROWS*cZC-1:0] parity_ref(logic [cDATA_COLS*cZC-1:0] blk);
    zdat_t                   acc [cPAR_ROWS];
    zdat_t                   prev;
    logic [cPAR_ROWS*cZC-1:0] res;
    int                      c;
    for (int r = 0; r < cPAR_ROWS; r++) begin
      acc[r] = '0;
    end
    for (int e = 0; e < cHS_ENTRIES; e++) begin
      c = int'(cHS_TABLE[e].col);
      acc[cHS_TABLE[e].row] ^= rotate_left(blk[c*cZC +: cZC], int'(cHS_TABLE[e].shift));
    end
    prev = '0;
    for (int r = 0; r < cPAR_ROWS; r++) begin
      prev = prev ^ acc[r];
      res[r*cZC +: cZC] = prev;
    end
    return res;
  endfunction

  task automatic fill_table();
    stim_words[0] = '0;
    holdoff[0]    = 2;
    stim_words[1] = '1;
    holdoff[1]    = 0;
    // single bit in word 0
    stim_words[2] = 32'h0000_0010;
    holdoff[2]    = 4;
    for (int b = 3; b < cNUM_BLOCKS; b++) begin
      for (int k = 0; k < cDATA_COLS * cZC; k++) begin
        stim_words[b][k] = lfsr[0];
        lfsr = lfsr_step(lfsr);
      end
    end
    holdoff[3] = 1;
    holdoff[4] = 6;
    holdoff[5] = 3;
  endtask

  //--------------------------------------------------------------------------
  // one block: hold-off, start, collect writes, compare
  //--------------------------------------------------------------------------

  task automatic run_block(int b);
    int                       nwrites;
    int                       nrempty;
    bit                       done;
    zdat_t                    got [8];
    logic [7:0]               seen;
    logic [cPAR_ROWS*cZC-1:0] par;
    col_t                     addr0;
    nwrites = 0;
    nrempty = 0;
    done    = 1'b0;
    seen    = '0;
    par     = parity_ref(stim_words[b]);
    // input buffer filled, output buffer not yet drained
    @(posedge iclk);
    for (int i = 0; i < cDATA_COLS; i++) begin
      ibuf[i] <= stim_words[b][i*cZC +: cZC];
    end
    ifull       <= 1'b1;
    iwbuf_empty <= 1'b0;
    addr0 = oraddr;
    repeat (holdoff[b]) begin
      @(posedge iclk);
      check_value($sformatf("block %0d holdoff oraddr", b), 32'(addr0), 32'(oraddr));
      check_value($sformatf("block %0d holdoff owrite", b), 0, 32'(owrite));
      check_value($sformatf("block %0d holdoff obusy", b), 0, 32'(obusy));
    end
    @(posedge iclk);
    iwbuf_empty <= 1'b1;
    while (!done) begin
      @(posedge iclk);
      // engine started, release both levels
      if (obusy && ifull) begin
        ifull       <= 1'b0;
        iwbuf_empty <= 1'b0;
      end
      if (owrite) begin
        nwrites++;
        seen[owaddr] = 1'b1;
        got[owaddr]  = owdat;
      end
      if (orempty) begin
        nrempty++;
      end
      if (owfull) begin
        check_value($sformatf("block %0d orempty before owfull", b), 1, nrempty);
        done = 1'b1;
      end
    end
    // cycle after block end must be quiet
    @(posedge iclk);
    check_value($sformatf("block %0d second owfull", b), 0, 32'(owfull));
    check_value($sformatf("block %0d late owrite", b), 0, 32'(owrite));
    check_value($sformatf("block %0d obusy after end", b), 0, 32'(obusy));
    check_value($sformatf("block %0d write count", b), cNUM_WORDS, nwrites);
    check_value($sformatf("block %0d addresses written", b), 32'h7f, 32'(seen));
    for (int i = 0; i < cDATA_COLS; i++) begin
      check_value($sformatf("block %0d data %0d", b, i),
                  32'(stim_words[b][i*cZC +: cZC]), 32'(got[i]));
    end
    for (int r = 0; r < cPAR_ROWS; r++) begin
      check_value($sformatf("block %0d parity %0d", b, r),
                  32'(par[r*cZC +: cZC]), 32'(got[cDATA_COLS + r]));
    end
  endtask

  //--------------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------------

  initial begin
    ireset      = 1'b1;
    ifull       = 1'b0;
    iwbuf_empty = 1'b0;
    lfsr        = cLFSR_SEED;
    fill_table();
    repeat (cRESET_CYCLES) @(posedge iclk);
    ireset <= 1'b0;
    // quiet engine with no stimulus
    repeat (cIDLE_CYCLES) begin
      @(posedge iclk);
      check_value("idle orempty", 0, 32'(orempty));
      check_value("idle owrite", 0, 32'(owrite));
      check_value("idle owfull", 0, 32'(owfull));
      check_value("idle obusy", 0, 32'(obusy));
    end
    for (int b = 0; b < cNUM_BLOCKS; b++) begin
      run_block(b);
    end
    assert_fails = DUT.u_assertions.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
